/* source/rv_mem_pkg.sv */
`default_nettype none

// instruction-side view of the memory stage
package rv_mem_pkg;

	typedef logic [31:0] data_word_t; // register file word
	typedef logic [4:0]  reg_idx_t;   // rd index
	typedef logic [2:0]  mem_op_t;    // access size, funct3 style

	// bit 1 = word, bit 0 clear = byte, bit 2 = sign extend
	localparam mem_op_t MEM_OP_LBU = 3'b000;
	localparam mem_op_t MEM_OP_LHU = 3'b001;
	localparam mem_op_t MEM_OP_LW  = 3'b010;
	localparam mem_op_t MEM_OP_LB  = 3'b100;
	localparam mem_op_t MEM_OP_LH  = 3'b101;

	typedef struct packed {
		logic     mem;      // load or store present
		logic     is_store; // 1 store, 0 load
		mem_op_t  op;
		reg_idx_t rd;
	} mem_ctrl_t;

	localparam mem_ctrl_t mem_ctrl_default = '0; // bubble

	function automatic logic op_is_word(mem_op_t op);
		return op[1];
	endfunction

	function automatic logic op_is_byte(mem_op_t op);
		return !op[1] && !op[0]; // halfword when neither
	endfunction

	function automatic logic op_sign_ext(mem_op_t op);
		return op[2];
	endfunction

endpackage

`default_nettype wire

/* source/mem_bus_pkg.sv */
`default_nettype none

// cache-side and memory-side bus types
package mem_bus_pkg;

	localparam int LINE_WORDS       = 4;
	localparam int LINE_BITS        = 128;
	localparam int WORD_IDX_BITS    = $clog2(LINE_WORDS);
	localparam int LINE_OFFSET_BITS = WORD_IDX_BITS + 2; // byte offset within a line

	typedef logic [31:0]              byte_addr_t;
	typedef logic [31:0]              byte_mask_t; // one bit per data bit
	typedef logic [LINE_BITS-1:0]     cache_line_t;
	typedef logic [WORD_IDX_BITS-1:0] word_idx_t;

	typedef struct packed {
		logic                   strobe; // single cycle
		logic                   write;
		byte_addr_t             addr;   // line aligned
		word_idx_t              word;   // word within the line for writes
		rv_mem_pkg::data_word_t wdata;
		byte_mask_t             wmask;
	} mem_req_t;

	typedef struct packed {
		logic        strobe; // single cycle
		cache_line_t rline;  // line after any write
	} mem_resp_t;

	// bit-wise merge of new data into an old word
	function automatic rv_mem_pkg::data_word_t merge_word(
		rv_mem_pkg::data_word_t old_word,
		rv_mem_pkg::data_word_t new_word,
		byte_mask_t             mask
	);
		return (old_word & ~mask) | (new_word & mask);
	endfunction

endpackage

`default_nettype wire

/* source/mem_access_unit.sv */
`timescale 1ns/1ps
`default_nettype none

// memory stage: latches one instruction, runs it through the cache, presents write-back
module mem_access_unit (
	input  wire logic                    i_clk,
	input  wire logic                    i_reset,

	// from execute
	input  rv_mem_pkg::mem_ctrl_t        i_ctrl,
	input  rv_mem_pkg::data_word_t       i_alu_result, // address for loads/stores
	input  rv_mem_pkg::data_word_t       i_rs2,        // store data

	// to write-back
	output rv_mem_pkg::reg_idx_t         o_rd,
	output rv_mem_pkg::data_word_t       o_rd_output,
	output logic                         o_pipeline_ready, // load strobe for the stage register

	// cache port
	output logic                         o_cache_valid,
	output logic                         o_cache_write,
	output mem_bus_pkg::byte_addr_t      o_cache_addr,
	output rv_mem_pkg::data_word_t       o_cache_wdata,
	output mem_bus_pkg::byte_mask_t      o_cache_wmask,
	input  wire logic                    i_cache_ready,
	input  wire logic                    i_cache_rvalid,
	input  rv_mem_pkg::data_word_t       i_cache_rdata
);
	import rv_mem_pkg::*;
	import mem_bus_pkg::*;

	typedef enum logic {
		U_STANDBY, // instruction latched, cache not yet asked
		U_ACCESS   // waiting on rvalid
	} unit_state_t;

	unit_state_t state, state_nxt;

	// stage register
	mem_ctrl_t  ctrl_q;
	data_word_t alu_q;
	data_word_t rs2_q;

	logic [1:0] lane;       // byte offset in the word
	logic [4:0] lane_shift; // same offset in bits
	byte_mask_t size_mask;  // mask before shifting into the lane
	data_word_t load_shifted;
	data_word_t load_value;

	assign lane       = alu_q[1:0];
	assign lane_shift = {lane, 3'b000};

	// store path
	always_comb begin
		if (op_is_word(ctrl_q.op))
			size_mask = 32'hffff_ffff;
		else if (op_is_byte(ctrl_q.op))
			size_mask = 32'h0000_00ff;
		else
			size_mask = 32'h0000_ffff; // halfword
	end

	assign o_cache_wmask = size_mask << lane_shift;
	assign o_cache_wdata = rs2_q << lane_shift; // bits above the lane are masked off
	assign o_cache_addr  = {alu_q[31:2], 2'b00}; // cache is word addressed
	assign o_cache_write = ctrl_q.is_store;

	// load path
	assign load_shifted = i_cache_rdata >> lane_shift;

	always_comb begin
		load_value = load_shifted;
		if (!op_is_word(ctrl_q.op)) begin
			if (op_is_byte(ctrl_q.op))
				load_value[31:8] = {24{op_sign_ext(ctrl_q.op) & load_shifted[7]}};
			else
				load_value[31:16] = {16{op_sign_ext(ctrl_q.op) & load_shifted[15]}};
		end
	end

	assign o_rd = ctrl_q.rd;

	// stage FSM
	always_comb begin
		state_nxt        = state;
		o_cache_valid    = 1'b0;
		o_pipeline_ready = 1'b0;
		o_rd_output      = alu_q; // pass-through for non-memory ops and stores

		case (state)
			U_STANDBY: begin
				o_pipeline_ready = !ctrl_q.mem; // non-memory op is done at once
				if (ctrl_q.mem && i_cache_ready) begin
					o_cache_valid = 1'b1; // single pulse, state leaves standby
					state_nxt     = U_ACCESS;
				end
			end
			U_ACCESS: begin
				if (!ctrl_q.is_store)
					o_rd_output = load_value;
				if (i_cache_rvalid) begin
					o_pipeline_ready = 1'b1;
					state_nxt        = U_STANDBY;
				end
			end
			default: state_nxt = U_STANDBY;
		endcase
	end

	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset) begin
			state  <= U_STANDBY;
			ctrl_q <= mem_ctrl_default; // idle after reset
		end else begin
			state <= state_nxt;
			if (o_pipeline_ready)
				ctrl_q <= i_ctrl;
		end
	end

	// operands load with the control word
	always_ff @(posedge i_clk) begin
		if (o_pipeline_ready) begin
			alu_q <= i_alu_result;
			rs2_q <= i_rs2;
		end
	end

	// driver must hand over naturally aligned accesses
	a_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
		(state == U_STANDBY && ctrl_q.mem) |->
			(op_is_word(ctrl_q.op) ? (lane == 2'b00) :
			 op_is_byte(ctrl_q.op) ? 1'b1 : !lane[0]))
		else $error("misaligned access at %h", alu_q);

	// request only into a ready cache, which then drops ready
	a_valid_ready: assert property (@(posedge i_clk) disable iff (i_reset)
		o_cache_valid |-> (i_cache_ready ##1 !i_cache_ready))
		else $error("cache request outside the ready window");

endmodule

`default_nettype wire

/* source/dcache_direct_mapped.sv */
`timescale 1ns/1ps
`default_nettype none

// direct-mapped data cache, write-through, allocate on read miss only
module dcache_direct_mapped #(
	parameter int CACHE_LINES = 16 // power of two
) (
	input  wire logic                i_clk,
	input  wire logic                i_reset,

	// cpu side, word aligned
	input  wire logic                i_valid,
	input  wire logic                i_write,
	input  mem_bus_pkg::byte_addr_t  i_addr,
	input  rv_mem_pkg::data_word_t   i_wdata,
	input  mem_bus_pkg::byte_mask_t  i_wmask,
	output logic                     o_ready,
	output logic                     o_rvalid,
	output rv_mem_pkg::data_word_t   o_rdata,

	// memory side
	output mem_bus_pkg::mem_req_t    o_mem_req,
	input  mem_bus_pkg::mem_resp_t   i_mem_resp
);
	import rv_mem_pkg::*;
	import mem_bus_pkg::*;

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int TAG_BITS   = 32 - LINE_OFFSET_BITS - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] line_idx_t;
	typedef logic [TAG_BITS-1:0]   tag_t;

	typedef enum logic [1:0] {
		C_IDLE,     // ready for a request
		C_LOOKUP,   // tag compare on the latched request
		C_WAIT_MEM, // one memory access outstanding
		C_RESPOND   // rvalid after refill or write-through
	} cache_state_t;

	cache_state_t state, state_nxt;

	// storage
	cache_line_t            line_data [CACHE_LINES];
	tag_t                   tag_q     [CACHE_LINES];
	logic [CACHE_LINES-1:0] valid_q;

	// latched request
	logic       req_write;
	byte_addr_t req_addr;
	data_word_t req_wdata;
	byte_mask_t req_wmask;

	// address split
	word_idx_t req_word;
	line_idx_t req_idx;
	tag_t      req_tag;

	cache_line_t cur_line;
	data_word_t  cur_word;
	logic        hit;

	assign req_word = req_addr[2 +: WORD_IDX_BITS];
	assign req_idx  = req_addr[LINE_OFFSET_BITS +: INDEX_BITS];
	assign req_tag  = req_addr[31 -: TAG_BITS];

	assign cur_line = line_data[req_idx];
	assign cur_word = cur_line[req_word*32 +: 32];
	assign hit      = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

	assign o_ready  = (state == C_IDLE);
	assign o_rdata  = cur_word; // valid on a read hit and after the refill
	assign o_rvalid = (state == C_LOOKUP && !req_write && hit) || (state == C_RESPOND);

	// memory request, strobed from lookup on a read miss or any write
	always_comb begin
		o_mem_req.strobe = (state == C_LOOKUP) && (req_write || !hit);
		o_mem_req.write  = req_write;
		o_mem_req.addr   = {req_addr[31:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
		o_mem_req.word   = req_word;
		o_mem_req.wdata  = req_wdata;
		o_mem_req.wmask  = req_wmask;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			C_IDLE:
				if (i_valid)
					state_nxt = C_LOOKUP;
			C_LOOKUP:
				if (!req_write && hit)
					state_nxt = C_IDLE; // read hit answered here
				else
					state_nxt = C_WAIT_MEM;
			C_WAIT_MEM:
				if (i_mem_resp.strobe)
					state_nxt = C_RESPOND;
			C_RESPOND:
				state_nxt = C_IDLE;
			default:
				state_nxt = C_IDLE;
		endcase
	end

	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset) begin
			state   <= C_IDLE;
			valid_q <= '0; // whole cache invalid
		end else begin
			state <= state_nxt;
			if (state == C_WAIT_MEM && i_mem_resp.strobe && !req_write)
				valid_q[req_idx] <= 1'b1; // refill done
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_valid && o_ready) begin
			req_write <= i_write;
			req_addr  <= i_addr;
			req_wdata <= i_wdata;
			req_wmask <= i_wmask;
		end

		// write hit updates the cached word, memory gets it as well
		if (state == C_LOOKUP && req_write && hit)
			line_data[req_idx][req_word*32 +: 32] <= merge_word(cur_word, req_wdata, req_wmask);

		// read miss installs the returned line, evicting what was there
		if (state == C_WAIT_MEM && i_mem_resp.strobe && !req_write) begin
			line_data[req_idx] <= i_mem_resp.rline;
			tag_q[req_idx]     <= req_tag;
		end
	end

	// memory answers only what was asked
	a_resp_outstanding: assert property (@(posedge i_clk) disable iff (i_reset)
		i_mem_resp.strobe |-> (state == C_WAIT_MEM))
		else $error("memory response without outstanding request");

endmodule

`default_nettype wire

/* source/main_memory_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// main memory model, one line per access, fixed latency, one request in flight
module main_memory_ctrl #(
	parameter int MEM_LATENCY = 4, // at least 1
	parameter int MEM_LINES   = 64 // power of two
) (
	input  wire logic              i_clk,
	input  wire logic              i_reset,
	input  mem_bus_pkg::mem_req_t  i_req,
	output mem_bus_pkg::mem_resp_t o_resp
);
	import mem_bus_pkg::*;

	localparam int MEM_IDX_BITS = $clog2(MEM_LINES);
	localparam int CNT_BITS     = $clog2(MEM_LATENCY + 1);

	typedef logic [MEM_IDX_BITS-1:0] mem_idx_t;

	cache_line_t mem_array [MEM_LINES] = '{default: '0}; // zero at start of simulation

	mem_idx_t            req_idx;  // line addressed by the incoming strobe
	mem_idx_t            pend_idx; // latched for the response
	logic                pending;
	logic [CNT_BITS-1:0] delay_cnt;
	cache_line_t         wr_line;

	assign req_idx = i_req.addr[LINE_OFFSET_BITS +: MEM_IDX_BITS]; // upper bits wrap

	// masked word merged into the addressed line
	always_comb begin
		wr_line = mem_array[req_idx];
		wr_line[i_req.word*32 +: 32] = merge_word(wr_line[i_req.word*32 +: 32], i_req.wdata,
			i_req.wmask);
	end

	always_ff @(posedge i_clk, posedge i_reset) begin
		if (i_reset) begin
			pending   <= 1'b0;
			delay_cnt <= '0;
		end else if (i_req.strobe) begin
			pending   <= 1'b1;
			delay_cnt <= CNT_BITS'(MEM_LATENCY - 1); // strobe lands MEM_LATENCY cycles on
		end else if (o_resp.strobe) begin
			pending <= 1'b0;
		end else if (pending) begin
			delay_cnt <= delay_cnt - 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_req.strobe) begin
			pend_idx <= req_idx;
			if (i_req.write)
				mem_array[req_idx] <= wr_line; // so the response shows the write
		end
	end

	assign o_resp.strobe = pending && (delay_cnt == '0);
	assign o_resp.rline  = mem_array[pend_idx];

	// cache keeps at most one access in flight
	a_single_outstanding: assert property (@(posedge i_clk) disable iff (i_reset)
		i_req.strobe |-> !pending)
		else $error("memory request while another is pending");

endmodule

`default_nettype wire

/* source/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

// memory stage: stage unit, data cache, main memory model
module mem_stage_top #(
	parameter int CACHE_LINES = 16,
	parameter int MEM_LATENCY = 4,
	parameter int MEM_LINES   = 64
) (
	input  wire logic              i_clk,
	input  wire logic              i_reset,
	input  rv_mem_pkg::mem_ctrl_t  i_ctrl,
	input  rv_mem_pkg::data_word_t i_alu_result,
	input  rv_mem_pkg::data_word_t i_rs2,
	output rv_mem_pkg::reg_idx_t   o_rd,
	output rv_mem_pkg::data_word_t o_rd_output,
	output logic                   o_pipeline_ready
);
	import rv_mem_pkg::*;
	import mem_bus_pkg::*;

	// unit <-> cache
	logic       cache_valid;
	logic       cache_write;
	byte_addr_t cache_addr;
	data_word_t cache_wdata;
	byte_mask_t cache_wmask;
	logic       cache_ready;
	logic       cache_rvalid;
	data_word_t cache_rdata;

	// cache <-> memory
	mem_req_t  mem_req;
	mem_resp_t mem_resp;

	mem_access_unit unit_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_ctrl(i_ctrl), .i_alu_result(i_alu_result), .i_rs2(i_rs2),
		.o_rd(o_rd), .o_rd_output(o_rd_output), .o_pipeline_ready(o_pipeline_ready),
		.o_cache_valid(cache_valid), .o_cache_write(cache_write), .o_cache_addr(cache_addr),
		.o_cache_wdata(cache_wdata), .o_cache_wmask(cache_wmask),
		.i_cache_ready(cache_ready), .i_cache_rvalid(cache_rvalid),
		.i_cache_rdata(cache_rdata)
	);

	dcache_direct_mapped #(.CACHE_LINES(CACHE_LINES)) dcache_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_valid(cache_valid), .i_write(cache_write), .i_addr(cache_addr),
		.i_wdata(cache_wdata), .i_wmask(cache_wmask),
		.o_ready(cache_ready), .o_rvalid(cache_rvalid), .o_rdata(cache_rdata),
		.o_mem_req(mem_req), .i_mem_resp(mem_resp)
	);

	main_memory_ctrl #(.MEM_LATENCY(MEM_LATENCY), .MEM_LINES(MEM_LINES)) mem_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_req(mem_req), .o_resp(mem_resp)
	);

endmodule

`default_nettype wire

/* verification/mem_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// random load/store/alu stream against a byte-wise shadow memory
module mem_stage_tb;
	import rv_mem_pkg::*;
	import mem_bus_pkg::*;

	localparam int CACHE_LINES    = 16;
	localparam int MEM_LATENCY    = 4;
	localparam int MEM_LINES      = 64;
	localparam int NUM_INSTR      = 600;
	localparam int LINE_IDX_BITS  = $clog2(MEM_LINES);
	localparam int MEM_BYTES      = MEM_LINES * LINE_WORDS * 4;
	localparam int ADDR_BITS      = $clog2(MEM_BYTES);
	localparam int TIMEOUT_CYCLES = NUM_INSTR * (MEM_LATENCY + 4) + 20;

	logic       clk = 1'b0;
	logic       reset;
	mem_ctrl_t  ctrl;
	data_word_t alu_result;
	data_word_t rs2;
	reg_idx_t   rd;
	data_word_t rd_output;
	logic       pipeline_ready;

	// reference state
	logic [7:0]               shadow [MEM_BYTES] = '{default: 8'h00}; // memory starts zeroed
	logic [31:0]              lfsr_state = 32'hc512bbdb;
	logic [LINE_IDX_BITS-1:0] last_line = '0; // reused to get store-then-load on one line
	logic                     pending = 1'b0; // an instruction sits in the stage register
	logic                     pend_mem;
	logic                     pend_store;
	int                       pend_num;
	reg_idx_t                 exp_rd;
	data_word_t               exp_data;
	int                       instr_cnt = 0;
	int                       age = 0;        // cycles since the latching edge
	int                       cycle_cnt = 0;

	mem_stage_top #(
		.CACHE_LINES(CACHE_LINES),
		.MEM_LATENCY(MEM_LATENCY),
		.MEM_LINES(MEM_LINES)
	) dut_i (
		.i_clk(clk), .i_reset(reset),
		.i_ctrl(ctrl), .i_alu_result(alu_result), .i_rs2(rs2),
		.o_rd(rd), .o_rd_output(rd_output), .o_pipeline_ready(pipeline_ready)
	);

	always #4 clk = ~clk; // 8 ns period

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "run stopped at the first failing check");
	endtask

	// galois lfsr stepped once per bit handed out
	function automatic logic [31:0] rand_bits(input int width);
		logic [31:0] value;
		int          i;
		value = '0;
		for (i = 0; i < width; i++) begin
			value[i]   = lfsr_state[0];
			lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	// returns the expected rd_output and applies stores to the shadow
	function automatic data_word_t model_access(mem_ctrl_t c, data_word_t addr, data_word_t data);
		int         nbytes;
		int         base;
		int         i;
		data_word_t value;
		nbytes = c.op[1] ? 4 : (c.op[0] ? 2 : 1); // word, halfword, byte
		base   = int'(addr[ADDR_BITS-1:0]);
		if (!c.mem || c.is_store) begin
			if (c.mem) begin
				for (i = 0; i < nbytes; i++)
					shadow[base + i] = data[8*i +: 8]; // little endian
			end
			return addr; // alu result passes through
		end
		value = '0;
		for (i = 0; i < nbytes; i++)
			value[8*i +: 8] = shadow[base + i];
		if (c.op[2] && value[8*nbytes-1]) begin
			for (i = nbytes; i < 4; i++)
				value[8*i +: 8] = 8'hff; // sign extension of LB / LH
		end
		return value;
	endfunction

	// next edge at which the stage register loads
	task automatic wait_ready_edge();
		@(posedge clk);
		while (reset || !pipeline_ready)
			@(posedge clk);
	endtask

	task automatic drive_instruction(input int k);
		mem_ctrl_t  c;
		data_word_t addr;
		logic [1:0] kind;
		logic [1:0] size;
		logic [1:0] offset;
		logic [1:0] word_sel;
		c        = mem_ctrl_default;
		kind     = 2'(rand_bits(2));
		size     = 2'(rand_bits(2));
		c.rd     = 5'(rand_bits(5));
		c.mem    = (k != 0) && (kind != 2'd0); // first one is a plain alu op
		c.is_store = (kind == 2'd1);          // roughly a third of memory ops store
		if (size[1])
			c.op = MEM_OP_LW;
		else if (size[0])
			c.op = rand_bits(1) ? MEM_OP_LH : MEM_OP_LHU;
		else
			c.op = rand_bits(1) ? MEM_OP_LB : MEM_OP_LBU;
		if (rand_bits(1) == 32'd0)
			last_line = LINE_IDX_BITS'(rand_bits(LINE_IDX_BITS)); // else stay on the line
		word_sel = 2'(rand_bits(2));
		offset   = 2'(rand_bits(2));
		if (size[1])
			offset = 2'b00;
		else if (size[0])
			offset[0] = 1'b0; // halfword alignment
		addr = '0;
		addr[3:0] = {word_sel, offset};
		addr[4 +: LINE_IDX_BITS] = last_line;
		if (!c.mem)
			addr = rand_bits(32);
		ctrl       <= c;
		alu_result <= addr;
		rs2        <= rand_bits(32);
	endtask

	initial begin
		reset      = 1'b1;
		ctrl       = mem_ctrl_default;
		alu_result = '0;
		rs2        = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int k = 0; k < NUM_INSTR; k++) begin
			wait_ready_edge();
			drive_instruction(k);
		end
		wait_ready_edge();        // last instruction latched
		ctrl <= mem_ctrl_default;
		wait_ready_edge();        // and retired
		#1;
		$display("All checks passed");
		$finish;
	end

	// reference model follows what the stage register actually loads
	always @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
			age     <= 0;
		end else if (pipeline_ready) begin
			pending    <= 1'b1;
			pend_mem   <= ctrl.mem;
			pend_store <= ctrl.is_store;
			pend_num   <= instr_cnt;
			exp_rd     <= ctrl.rd;
			exp_data   <= model_access(ctrl, alu_result, rs2);
			instr_cnt  <= instr_cnt + 1;
			age        <= 0;
		end else begin
			age <= age + 1;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
			stop_with_failure("timeout: the stage stopped accepting instructions");
	end

	a_ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> pipeline_ready)
		else stop_with_failure("Fail ready_after_reset: expected 1 actual 0");

	a_rd: assert property (@(posedge clk) disable iff (reset)
		(pending && pipeline_ready) |-> (rd == exp_rd))
		else stop_with_failure($sformatf("Fail rd instr %0d: expected %0d actual %0d",
			$sampled(pend_num), $sampled(exp_rd), $sampled(rd)));

	a_alu_pass: assert property (@(posedge clk) disable iff (reset)
		(pending && !pend_mem && pipeline_ready) |-> (rd_output == exp_data))
		else stop_with_failure($sformatf("Fail alu_pass instr %0d: expected %h actual %h",
			$sampled(pend_num), $sampled(exp_data), $sampled(rd_output)));

	a_store_pass: assert property (@(posedge clk) disable iff (reset)
		(pending && pend_mem && pend_store && pipeline_ready) |-> (rd_output == exp_data))
		else stop_with_failure($sformatf("Fail store_pass instr %0d: expected %h actual %h",
			$sampled(pend_num), $sampled(exp_data), $sampled(rd_output)));

	// covers every size, extension, hit, refill and eviction seen by loads
	a_load_data: assert property (@(posedge clk) disable iff (reset)
		(pending && pend_mem && !pend_store && pipeline_ready) |-> (rd_output == exp_data))
		else stop_with_failure($sformatf("Fail load_data instr %0d: expected %h actual %h",
			$sampled(pend_num), $sampled(exp_data), $sampled(rd_output)));

	a_mem_not_early: assert property (@(posedge clk) disable iff (reset)
		(pending && pend_mem && pipeline_ready) |-> (age >= 1))
		else stop_with_failure($sformatf("Fail mem_not_early instr %0d: expected 1 actual %0d",
			$sampled(pend_num), $sampled(age)));

	a_mem_latency: assert property (@(posedge clk) disable iff (reset)
		pending |-> (age < MEM_LATENCY + 3))
		else stop_with_failure($sformatf("Fail mem_latency instr %0d: expected %0d actual %0d",
			$sampled(pend_num), MEM_LATENCY + 2, $sampled(age)));

endmodule

`default_nettype wire

/* sources.f */
source/rv_mem_pkg.sv
source/mem_bus_pkg.sv
source/mem_access_unit.sv
source/dcache_direct_mapped.sv
source/main_memory_ctrl.sv
source/mem_stage_top.sv
verification/mem_stage_tb.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  # packages first, the bus package uses the instruction package
  - source/rv_mem_pkg.sv
  - source/mem_bus_pkg.sv
  # design
  - source/mem_access_unit.sv
  - source/dcache_direct_mapped.sv
  - source/main_memory_ctrl.sv
  - source/mem_stage_top.sv
  # testbench
  - target: test
    files:
      - verification/mem_stage_tb.sv
